// ==== sim.f ====
src/rgmii_pkg.sv
src/frame_fifo.sv
src/packet_recv.sv
src/udp_rx_top.sv
verif/udp_rx_props.sv
verif/tb_udp_rx.sv

// ==== Bender.yml ====
package:
  name: udp_rx

sources:
  - files:
      - src/rgmii_pkg.sv
      - src/frame_fifo.sv
      - src/packet_recv.sv
      - src/udp_rx_top.sv

  - target: test
    files:
      - verif/udp_rx_props.sv
      - verif/tb_udp_rx.sv

// ==== verif/tb_udp_rx.sv ====
`timescale 1ns/10ps

module tb_udp_rx;
    import rgmii_pkg::*;

    localparam int NUM_FRAMES  = 40;
    localparam int MAX_CYCLES  = NUM_FRAMES * 200;
    localparam int DRAIN_LIMIT = 200;
    localparam int IDLE_GAP    = 12;

    localparam logic [7:0] PRE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE = 8'hD5;

    localparam int K_GOOD     = 0;
    localparam int K_MISMATCH = 1;
    localparam int K_BAD_SFD  = 2;
    localparam int K_TRUNC    = 3;

    logic                     clk_i = 1'b0; // low from the start, so time 0 sees no falling edge
    logic                     rst_i;
    logic [GMII_WIDTH-1:0]    rx_d_i;
    logic                     rx_dv_i;
    logic [PAYLOAD_WIDTH-1:0] payload_bytes_i;
    logic [47:0]              host_mac_i;
    logic [GMII_WIDTH-1:0]    m_tdata_o;
    logic                     m_tvalid_o;
    logic                     m_tlast_o;
    logic                     m_tready_i;

    integer     seed;
    int         cycle_cnt;
    int         err_data;
    int         err_last;
    int         err_other;
    int         err_total;
    int         kind_cnt [4];
    logic [8:0] exp_q [$]; // {last, data} in wire order

    udp_rx_top u_udp_rx_top (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .rx_d_i          (rx_d_i),
        .rx_dv_i         (rx_dv_i),
        .payload_bytes_i (payload_bytes_i),
        .host_mac_i      (host_mac_i),
        .m_tdata_o       (m_tdata_o),
        .m_tvalid_o      (m_tvalid_o),
        .m_tlast_o       (m_tlast_o),
        .m_tready_i      (m_tready_i)
    );

    bind udp_rx_top udp_rx_props u_udp_rx_props (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .tdata_i  (m_tdata_o),
        .tvalid_i (m_tvalid_o),
        .tlast_i  (m_tlast_o),
        .tready_i (m_tready_i),
        .state_i  (u_packet_recv.state)
    );

    always #4 clk_i = ~clk_i;

    // ready is redrawn every cycle, low about a quarter of the time
    task automatic next_cycle();
        @(posedge clk_i);
        #1;
        m_tready_i = (($random(seed) & 3) != 0);
    endtask

    task automatic send_byte(input logic [7:0] b);
        next_cycle();
        rx_d_i  = b;
        rx_dv_i = 1'b1;
    endtask

    task automatic send_idle(input int n);
        repeat (n) begin
            next_cycle();
            rx_d_i  = '0;
            rx_dv_i = 1'b0;
        end
    endtask

    task automatic wait_drain(input int frame);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
            send_idle(1);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("frame %0d: %0d expected payload bytes never left the DUT",
                     frame, exp_q.size());
            err_other += exp_q.size();
            exp_q.delete();
        end
    endtask

    task automatic send_frame(input int kind);
        logic [7:0]  payload [64];
        logic [47:0] flip;
        logic [47:0] dst_mac;
        logic [7:0]  sfd;
        int          len;
        int          hdr_len;
        len  = ($unsigned($random(seed)) % 64) + 1;
        flip = {16'h0, $random(seed)};
        flip[0] = 1'b1;
        dst_mac = (kind == K_MISMATCH) ? (host_mac_i ^ flip) : host_mac_i;
        sfd = SFD_BYTE;
        if (kind == K_BAD_SFD) begin
            sfd = SFD_BYTE ^ (8'h01 << ($unsigned($random(seed)) % 7)); // never turns into 0x55
        end
        hdr_len = HEADER_BYTES;
        if (kind == K_TRUNC) begin
            hdr_len = ($unsigned($random(seed)) % (HEADER_BYTES - 1)) + 1;
        end
        for (int i = 0; i < len; i++) begin
            payload[i] = 8'($random(seed));
            if (kind == K_GOOD) begin
                exp_q.push_back({(i == len - 1), payload[i]});
            end
        end
        payload_bytes_i = PAYLOAD_WIDTH'(len);

        for (int i = 0; i < 7; i++) begin
            send_byte(PRE_BYTE);
        end
        send_byte(sfd);
        for (int i = 0; i < hdr_len; i++) begin
            if (i < MAC_BYTES) begin
                send_byte(dst_mac[47 - 8 * i -: 8]); // most significant byte first
            end else begin
                send_byte(8'($random(seed)));
            end
        end
        if (kind != K_TRUNC) begin
            for (int i = 0; i < len; i++) begin
                send_byte(payload[i]);
            end
            for (int i = 0; i < FCS_BYTES; i++) begin
                send_byte(8'($random(seed)));
            end
        end
        send_idle(IDLE_GAP);
    endtask

    // values seen here are the ones present at the following rising edge
    always @(negedge clk_i) begin
        logic [8:0] exp_word;
        if (rst_i) begin
            if (m_tvalid_o !== 1'b0) begin
                $display("ERROR at %0t: m_tvalid_o expected 0, got %b", $time, m_tvalid_o);
                err_other++;
            end
        end else if (m_tvalid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("output valid at %0t while no payload byte was expected (data %02h)",
                         $time, m_tdata_o);
                err_other++;
            end else if (m_tready_i) begin
                exp_word = exp_q.pop_front();
                if (m_tdata_o !== exp_word[7:0]) begin
                    $display("ERROR at %0t: m_tdata_o expected %02h, got %02h",
                             $time, exp_word[7:0], m_tdata_o);
                    err_data++;
                end
                if (m_tlast_o !== exp_word[8]) begin
                    $display("ERROR at %0t: m_tlast_o expected %b, got %b",
                             $time, exp_word[8], m_tlast_o);
                    err_last++;
                end
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int   kind;
        int   r;
        logic prev_bad;
        $timeformat(-9, 0, " ns", 0);
        seed            = 32'h5fd92173;
        rst_i           = 1'b1;
        rx_d_i          = '0;
        rx_dv_i         = 1'b0;
        payload_bytes_i = '0;
        m_tready_i      = 1'b0;
        host_mac_i      = {16'($random(seed)), 32'($random(seed))};
        err_data        = 0;
        err_last        = 0;
        err_other       = 0;
        prev_bad        = 1'b0;
        for (int k = 0; k < 4; k++) begin
            kind_cnt[k] = 0;
        end

        repeat (2) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        send_idle(4);

        for (int f = 0; f < NUM_FRAMES; f++) begin
            r = $unsigned($random(seed)) % 8;
            case (f)
                1:       kind = K_MISMATCH;
                2:       kind = K_BAD_SFD;
                4:       kind = K_TRUNC;
                default: kind = (r < 4) ? r : K_GOOD;
            endcase
            if (prev_bad) begin
                kind = K_GOOD; // a damaged frame is always followed by a clean one
            end
            send_frame(kind);
            wait_drain(f);
            kind_cnt[kind]++;
            prev_bad = (kind == K_BAD_SFD) || (kind == K_TRUNC);
        end
        send_idle(20);

        err_other += exp_q.size();
        err_total = err_data + err_last + err_other + u_udp_rx_top.u_udp_rx_props.fail_cnt;
        $display("frames sent: %0d good, %0d other MAC, %0d bad SFD, %0d truncated",
                 kind_cnt[K_GOOD], kind_cnt[K_MISMATCH], kind_cnt[K_BAD_SFD],
                 kind_cnt[K_TRUNC]);
        $display("errors: %0d total (data %0d, last %0d, other %0d, assertion %0d)",
                 err_total, err_data, err_last, err_other,
                 u_udp_rx_top.u_udp_rx_props.fail_cnt);
        if (err_total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== verif/udp_rx_props.sv ====
`timescale 1ns/10ps

module udp_rx_props (
    input logic                             clk_i,
    input logic                             rst_i,
    input logic [rgmii_pkg::GMII_WIDTH-1:0] tdata_i,
    input logic                             tvalid_i,
    input logic                             tlast_i,
    input logic                             tready_i,
    input rgmii_pkg::rx_state_t             state_i
);
    import rgmii_pkg::*;

    int fail_cnt = 0; // the testbench folds this into its error total

    stall_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        (tvalid_i && !tready_i) |=> (tvalid_i && $stable(tdata_i) && $stable(tlast_i)))
    else begin
        fail_cnt++;
        $error("output byte or last flag changed while the stream was stalled");
    end

    reset_quiet: assert property (@(posedge clk_i)
        rst_i |=> (!tvalid_i && !tlast_i))
    else begin
        fail_cnt++;
        $error("output valid or last flag high in the cycle after reset");
    end

    // a frame always passes through the preamble and header states first
    no_skip: assert property (@(posedge clk_i) disable iff (rst_i)
        (state_i == IDLE) |=> (state_i != DATA))
    else begin
        fail_cnt++;
        $error("receiver FSM went from IDLE straight to DATA");
    end

endmodule

// ==== src/udp_rx_top.sv ====
`timescale 1ns/10ps

module udp_rx_top (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic [rgmii_pkg::GMII_WIDTH-1:0]    rx_d_i,
    input  logic                                rx_dv_i,
    input  logic [rgmii_pkg::PAYLOAD_WIDTH-1:0] payload_bytes_i,
    input  logic [47:0]                         host_mac_i,
    output logic [rgmii_pkg::GMII_WIDTH-1:0]    m_tdata_o,
    output logic                                m_tvalid_o,
    output logic                                m_tlast_o,
    input  logic                                m_tready_i
);

    // receive path only, the frame FIFO sits inside the parser
    packet_recv u_packet_recv (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .rx_d_i          (rx_d_i),
        .rx_dv_i         (rx_dv_i),
        .payload_bytes_i (payload_bytes_i),
        .host_mac_i      (host_mac_i),
        .m_tdata_o       (m_tdata_o),
        .m_tvalid_o      (m_tvalid_o),
        .m_tlast_o       (m_tlast_o),
        .m_tready_i      (m_tready_i)
    );

endmodule

// ==== src/packet_recv.sv ====
`timescale 1ns/10ps

module packet_recv (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic [rgmii_pkg::GMII_WIDTH-1:0]    rx_d_i,
    input  logic                                rx_dv_i,
    input  logic [rgmii_pkg::PAYLOAD_WIDTH-1:0] payload_bytes_i,
    input  logic [47:0]                         host_mac_i,
    output logic [rgmii_pkg::GMII_WIDTH-1:0]    m_tdata_o,
    output logic                                m_tvalid_o,
    output logic                                m_tlast_o,
    input  logic                                m_tready_i
);
    import rgmii_pkg::*;

    logic [2:0][GMII_WIDTH-1:0] rxd_z;
    logic [2:0]                 rxdv_z;
    logic                       pkt_start;
    logic                       pkt_done;

    rx_state_t                  state;
    rx_state_t                  next_state;
    logic [PAYLOAD_WIDTH-1:0]   state_cnt;

    logic [63:0]                          pre_sr;
    logic [63:0]                          pre_next;
    logic [HEADER_BYTES*GMII_WIDTH-1:0]   hdr_sr;
    logic [MAC_BYTES*GMII_WIDTH-1:0]      dst_mac;
    logic                                 mac_match;

    logic                  wr_en;
    logic [GMII_WIDTH-1:0] wr_data;
    logic                  wr_last;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rxdv_z <= '0;
        end else begin
            rxdv_z <= {rxdv_z[1:0], rx_dv_i};
        end
    end

    always_ff @(posedge clk_i) begin
        rxd_z <= {rxd_z[1:0], rx_d_i};
    end

    assign pkt_start = !rxdv_z[2] && rxdv_z[1];
    assign pkt_done  = rxdv_z[2] && !rxdv_z[1]; // rxd_z[2] holds the last byte of the frame

    // newest byte enters at the top, so the SFD ends up in the high byte
    assign pre_next = {rxd_z[2], pre_sr[63:GMII_WIDTH]};

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (pkt_start) begin
                    next_state = PREAMBLE_SFD;
                end
            end
            PREAMBLE_SFD: begin
                if (pkt_done) begin
                    next_state = IDLE; // SFD never seen in this frame
                end else if (pre_next == {SFD_VAL, PREAMBLE_VAL}) begin
                    next_state = HEADER;
                end
            end
            HEADER: begin
                if (pkt_done) begin
                    next_state = IDLE;
                end else if (state_cnt == HEADER_BYTES - 1) begin
                    next_state = DATA;
                end
            end
            DATA: begin
                if (state_cnt == payload_bytes_i - 1'b1) begin
                    next_state = FCS;
                end
            end
            FCS: begin
                if (state_cnt == FCS_BYTES - 1) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state     <= IDLE;
            state_cnt <= '0;
        end else begin
            state <= next_state;
            if (state != next_state) begin
                state_cnt <= '0; // every state counts from zero
            end else begin
                state_cnt <= state_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == IDLE) begin
            pre_sr <= '0; // no stale delimiter carried into the next frame
        end else if (state == PREAMBLE_SFD) begin
            pre_sr <= pre_next;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == HEADER) begin
            hdr_sr <= {hdr_sr[HEADER_BYTES*GMII_WIDTH-GMII_WIDTH-1:0], rxd_z[2]};
        end
    end

    // first wire byte has been shifted to the top after 42 bytes
    assign dst_mac   = hdr_sr[HEADER_BYTES*GMII_WIDTH-1 -: MAC_BYTES*GMII_WIDTH];
    assign mac_match = (dst_mac == host_mac_i);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_en   <= 1'b0;
            wr_last <= 1'b0;
        end else begin
            wr_en   <= (state == DATA) && mac_match;
            wr_last <= (state == DATA) && mac_match && (next_state == FCS);
        end
    end

    always_ff @(posedge clk_i) begin
        wr_data <= rxd_z[2];
    end

    frame_fifo u_frame_fifo (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .wr_en_i    (wr_en),
        .wr_data_i  (wr_data),
        .wr_last_i  (wr_last),
        .m_tdata_o  (m_tdata_o),
        .m_tvalid_o (m_tvalid_o),
        .m_tlast_o  (m_tlast_o),
        .m_tready_i (m_tready_i)
    );

endmodule

// ==== src/frame_fifo.sv ====
`timescale 1ns/10ps

module frame_fifo (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             wr_en_i,
    input  logic [rgmii_pkg::GMII_WIDTH-1:0] wr_data_i,
    input  logic                             wr_last_i,
    output logic [rgmii_pkg::GMII_WIDTH-1:0] m_tdata_o,
    output logic                             m_tvalid_o,
    output logic                             m_tlast_o,
    input  logic                             m_tready_i
);
    import rgmii_pkg::*;

    logic [GMII_WIDTH:0]      mem [FIFO_DEPTH]; // {last, data}
    logic [PAYLOAD_WIDTH-1:0] wr_ptr;
    logic [PAYLOAD_WIDTH-1:0] rd_ptr;
    logic [PAYLOAD_WIDTH:0]   count;

    logic full;
    logic empty;
    logic load_out;
    logic bypass;
    logic push;
    logic pop;

    assign full     = (count == FIFO_DEPTH);
    assign empty    = (count == 0);
    assign load_out = !m_tvalid_o || m_tready_i; // output register free or being drained
    assign bypass   = load_out && empty && wr_en_i;
    assign pop      = load_out && !empty;
    assign push     = wr_en_i && !full && !bypass;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= {wr_last_i, wr_data_i};
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            m_tvalid_o <= 1'b0;
            m_tlast_o  <= 1'b0;
        end else if (load_out) begin
            if (!empty) begin
                {m_tlast_o, m_tdata_o} <= mem[rd_ptr];
                m_tvalid_o             <= 1'b1;
            end else if (wr_en_i) begin
                // nothing stored ahead of it, so the new byte goes straight out
                m_tdata_o  <= wr_data_i;
                m_tlast_o  <= wr_last_i;
                m_tvalid_o <= 1'b1;
            end else begin
                m_tvalid_o <= 1'b0;
                m_tlast_o  <= 1'b0;
            end
        end
    end

endmodule

// ==== src/rgmii_pkg.sv ====
package rgmii_pkg;

    // one GMII symbol per clock
    localparam int GMII_WIDTH = 8;

    // also sets the FIFO depth, so a maximum payload always fits
    localparam int PAYLOAD_WIDTH = 11;

    // ethernet 14 + ipv4 20 + udp 8
    localparam int HEADER_BYTES = 42;

    localparam int FCS_BYTES = 4;

    // destination MAC leads the header, most significant byte first
    localparam int MAC_BYTES = 6;

    localparam logic [55:0] PREAMBLE_VAL = 56'h55_55_55_55_55_55_55;
    localparam logic [7:0]  SFD_VAL      = 8'hD5;

    localparam int FIFO_DEPTH = 2 ** PAYLOAD_WIDTH;

    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE_SFD,
        HEADER,
        DATA,
        FCS
    } rx_state_t;

endpackage
